/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_copy_engine
FILELIST := verilog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/copy_engine_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// streaming copy engine: store streamer and load streamer share one
// scratch memory through the round-robin mixer
// read back a region only after its store job has signalled done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module copy_engine_top import mem_pkg::*, stream_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  job_t  load_job,
  input  logic  load_start,
  output logic  load_busy,
  output logic  load_done,
  input  job_t  store_job,
  input  logic  store_start,
  output logic  store_busy,
  output logic  store_done,
  input  beat_t in_beat,
  input  logic  in_valid,
  output logic  in_ready,
  output beat_t out_beat,
  output logic  out_valid,
  input  logic  out_ready
);

  mem_req_t load_req, store_req, mem_req;
  mem_rsp_t load_rsp, store_rsp, mem_rsp;

  load_streamer u_load (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .job       (load_job),
    .start     (load_start),
    .busy      (load_busy),
    .done      (load_done),
    .mem_req   (load_req),
    .mem_rsp   (load_rsp),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  store_streamer u_store (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .job      (store_job),
    .start    (store_start),
    .busy     (store_busy),
    .done     (store_done),
    .in_beat  (in_beat),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .mem_req  (store_req),
    .mem_rsp  (store_rsp)
  );

  load_store_mixer u_mixer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .load_req  (load_req),
    .load_rsp  (load_rsp),
    .store_req (store_req),
    .store_rsp (store_rsp),
    .out_req   (mem_req),
    .out_rsp   (mem_rsp)
  );

  scratch_mem u_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req    (mem_req),
    .rsp    (mem_rsp)
  );

endmodule

/* hdl/load_store_mixer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-channel round-robin mux of load and store onto one memory port
// request to gnt is combinational; every read response goes to the load side,
// so the store channel must only ever issue writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module load_store_mixer import mem_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mem_req_t load_req,
  output mem_rsp_t load_rsp,
  input  mem_req_t store_req,
  output mem_rsp_t store_rsp,
  output mem_req_t out_req,
  input  mem_rsp_t out_rsp
);

  logic rr_q;      // 0: load has priority, 1: store has priority
  logic store_win;
  logic hs;        // granted handshake on the memory port

  // priority only matters when both channels request
  always_comb begin
    if (load_req.req && store_req.req)
      store_win = rr_q;
    else
      store_win = store_req.req;
  end

  assign out_req = store_win ? store_req : load_req;
  assign hs      = out_req.req & out_rsp.gnt;

  // counter moves past the winner on each handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      rr_q <= 1'b0;
    else if (hs)
      rr_q <= ~store_win;
  end

  always_comb begin
    load_rsp  = '0;
    store_rsp = '0;

    load_rsp.gnt  = out_rsp.gnt & load_req.req & ~store_win;
    store_rsp.gnt = out_rsp.gnt & store_win;

    // reads only come from the load channel
    load_rsp.r_valid = out_rsp.r_valid;
    load_rsp.r_data  = out_rsp.r_data;
  end

  // the refused channel keeps its request and wins the next granted cycle
  a_rr_alternate : assert property (@(posedge clk_i) disable iff (!rst_ni)
    hs && load_req.req && store_req.req |=>
      !out_rsp.gnt || (store_win != $past(store_win)))
    else $error("refused channel did not win the next cycle");

  // a response must trace back to a read granted in the previous cycle
  a_rvalid_after_read : assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_rsp.r_valid |-> $past(hs && out_req.wen && !store_win))
    else $error("r_valid without a granted load read");

endmodule

/* hdl/load_streamer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reads job.len words from job.base and sends them out as a stream
// reads in flight never exceed the free fifo space, so responses always fit
// the address wraps at the top of memory; start is ignored while busy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module load_streamer import mem_pkg::*, stream_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  job_t     job,
  input  logic     start,
  output logic     busy,
  output logic     done,
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp,
  output beat_t    out_beat,
  output logic     out_valid,
  input  logic     out_ready
);

  logic              busy_q, done_q;
  logic [MEM_AW-1:0] addr_q;
  logic [MEM_AW:0]   issue_left_q, beats_left_q;
  logic [FIFO_CW-1:0] inflight_q, fifo_free;
  logic              issue, pop, last_beat, fifo_in_ready;
  beat_t             rd_beat;

  assign mem_req.req  = busy_q & (issue_left_q != '0) & (fifo_free > inflight_q);
  assign mem_req.wen  = 1'b1;
  assign mem_req.add  = addr_q;
  assign mem_req.data = '0;

  assign issue     = mem_req.req & mem_rsp.gnt;
  assign pop       = out_valid & out_ready;
  assign last_beat = busy_q & pop & (beats_left_q == 1);
  assign rd_beat.data = mem_rsp.r_data;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      done_q       <= 1'b0;
      addr_q       <= '0;
      issue_left_q <= '0;
      beats_left_q <= '0;
      inflight_q   <= '0;
    end else begin
      done_q <= last_beat;
      if (start && !busy_q) begin
        busy_q       <= 1'b1;
        addr_q       <= job.base;
        issue_left_q <= job.len;
        beats_left_q <= job.len;
      end else begin
        if (last_beat)
          busy_q <= 1'b0;
        if (issue) begin
          addr_q       <= addr_q + 1'b1;
          issue_left_q <= issue_left_q - 1'b1;
        end
        if (busy_q && pop)
          beats_left_q <= beats_left_q - 1'b1;
      end
      if (issue != mem_rsp.r_valid)
        inflight_q <= issue ? inflight_q + 1'b1 : inflight_q - 1'b1;
    end
  end

  stream_fifo #(.payload_t(beat_t)) u_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .in_data   (rd_beat),
    .in_valid  (mem_rsp.r_valid),
    .in_ready  (fifo_in_ready),
    .out_data  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .free      (fifo_free)
  );

  assign busy = busy_q;
  assign done = done_q;

  // credit scheme holds across memory latency
  a_rsp_fits : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rsp.r_valid |-> fifo_in_ready)
    else $error("read response arrived with the fifo full");

endmodule

/* hdl/mem_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory-side constants and the request/grant structs
// all accesses are full words, there are no byte enables and no error response
// wen is high for a read, as on the existing request/grant fabric
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_pkg;

  // word addressing, so MEM_AW bits cover the whole scratch memory
  localparam int unsigned MEM_AW    = 8;
  localparam int unsigned MEM_DW    = 32;
  localparam int unsigned MEM_WORDS = 2 ** MEM_AW;

  // master to slave; hold req until gnt is seen in the same cycle
  typedef struct packed {
    logic              req;
    logic              wen;   // 1: read, 0: write
    logic [MEM_AW-1:0] add;   // word address
    logic [MEM_DW-1:0] data;  // write data, ignored on reads
  } mem_req_t;

  // slave to master
  // r_valid pulses one cycle after a granted read
  typedef struct packed {
    logic              gnt;
    logic              r_valid;
    logic [MEM_DW-1:0] r_data;
  } mem_rsp_t;

endpackage

/* hdl/scratch_mem.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-port word memory, always grants
// read data returns one cycle after the request; contents are not reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scratch_mem import mem_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mem_req_t req,
  output mem_rsp_t rsp
);

  logic [MEM_DW-1:0] mem_q [MEM_WORDS];
  logic [MEM_DW-1:0] r_data_q;
  logic              r_valid_q;
  logic              rd, wr;

  assign rd = req.req & req.wen;
  assign wr = req.req & ~req.wen;

  always_ff @(posedge clk_i) begin
    if (wr)
      mem_q[req.add] <= req.data;
    if (rd)
      r_data_q <= mem_q[req.add]; // held until the next read
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      r_valid_q <= 1'b0;
    else
      r_valid_q <= rd;
  end

  assign rsp.gnt     = req.req;
  assign rsp.r_valid = r_valid_q;
  assign rsp.r_data  = r_data_q;

endmodule

/* hdl/store_streamer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writes job.len words from the input stream to memory from job.base on
// in_ready stays low outside a job and after job.len words have been taken
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module store_streamer import mem_pkg::*, stream_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  job_t     job,
  input  logic     start,
  output logic     busy,
  output logic     done,
  input  beat_t    in_beat,
  input  logic     in_valid,
  output logic     in_ready,
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp
);

  logic              busy_q, done_q;
  logic [MEM_AW-1:0] addr_q;
  logic [MEM_AW:0]   accept_left_q, write_left_q;
  logic              take, accepting, fifo_in_ready, head_valid, last_write;
  beat_t             head;

  assign accepting = busy_q & (accept_left_q != '0);
  assign in_ready  = accepting & fifo_in_ready;
  assign take      = in_valid & in_ready;

  // head of the fifo is the pending write
  assign mem_req.req  = busy_q & head_valid;
  assign mem_req.wen  = 1'b0;
  assign mem_req.add  = addr_q;
  assign mem_req.data = head.data;

  assign last_write = busy_q & mem_rsp.gnt & (write_left_q == 1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q        <= 1'b0;
      done_q        <= 1'b0;
      addr_q        <= '0;
      accept_left_q <= '0;
      write_left_q  <= '0;
    end else begin
      done_q <= last_write;
      if (start && !busy_q) begin
        busy_q        <= 1'b1;
        addr_q        <= job.base;
        accept_left_q <= job.len;
        write_left_q  <= job.len;
      end else begin
        if (take)
          accept_left_q <= accept_left_q - 1'b1;
        if (mem_rsp.gnt) begin  // gnt only comes with our own req
          addr_q       <= addr_q + 1'b1;
          write_left_q <= write_left_q - 1'b1;
        end
        if (last_write)
          busy_q <= 1'b0;
      end
    end
  end

  stream_fifo #(.payload_t(beat_t)) u_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .in_data   (in_beat),
    .in_valid  (in_valid & accepting),
    .in_ready  (fifo_in_ready),
    .out_data  (head),
    .out_valid (head_valid),
    .out_ready (mem_rsp.gnt),   // pop on grant
    .free      ()
  );

  assign busy = busy_q;
  assign done = done_q;

endmodule

/* hdl/stream_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// valid/ready fifo of FIFO_DEPTH entries, no fall-through
// a word pushed in one cycle is visible at the output in the next
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stream_fifo import stream_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  payload_t           in_data,
  input  logic               in_valid,
  output logic               in_ready,
  output payload_t           out_data,
  output logic               out_valid,
  input  logic               out_ready,
  output logic [FIFO_CW-1:0] free
);

  payload_t           buf_q [FIFO_DEPTH];
  logic [FIFO_PW-1:0] wr_ptr_q, rd_ptr_q;
  logic [FIFO_CW-1:0] cnt_q;
  logic               push, pop;

  assign in_ready  = (cnt_q != FIFO_CW'(FIFO_DEPTH));
  assign out_valid = (cnt_q != '0);
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;
  assign out_data  = buf_q[rd_ptr_q];
  assign free      = FIFO_CW'(FIFO_DEPTH) - cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == FIFO_PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == FIFO_PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push != pop)
        cnt_q <= push ? cnt_q + 1'b1 : cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push)
      buf_q[wr_ptr_q] <= in_data; // payload only, no reset
  end

  // a beat offered to a full fifo is not pushed, so it must stay offered unchanged
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid && (cnt_q == FIFO_CW'(FIFO_DEPTH)) |=> in_valid && $stable(in_data))
    else $error("beat offered to a full fifo was dropped");

endmodule

/* hdl/stream_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream beat and job descriptor used by both streamers
// a job length of zero is not supported, len must be 1 .. MEM_WORDS
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package stream_pkg;

  import mem_pkg::*;

  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PW    = $clog2(FIFO_DEPTH);     // pointer width
  localparam int unsigned FIFO_CW    = $clog2(FIFO_DEPTH + 1); // occupancy width

  typedef struct packed {
    logic [MEM_DW-1:0] data;
  } beat_t;

  // one extra len bit so a full-memory job fits
  typedef struct packed {
    logic [MEM_AW-1:0] base;
    logic [MEM_AW:0]   len;
  } job_t;

endpackage

/* testbench/tb_copy_engine.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for copy_engine_top, stops at the first error
// loads only read regions that a finished store job has written
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_copy_engine import mem_pkg::*, stream_pkg::*; ();

  localparam int DRIVE_DELAY = 10;  // inputs change this long after the rising edge
  localparam int WAIT_LIMIT  = 300; // cycles per wait

  logic  clk_i = 1'b0;
  logic  rst_ni;
  job_t  load_job, store_job;
  logic  load_start, load_busy, load_done, store_start, store_busy, store_done;
  beat_t in_beat, out_beat;
  logic  in_valid, in_ready, out_valid, out_ready;

  logic [MEM_DW-1:0] ref_mem [MEM_WORDS]; // mirror of every word sent to the store stream
  logic [31:0]       rng_state;
  logic [MEM_AW-1:0] exp_base;
  logic [MEM_AW:0]   exp_len, beat_idx;
  int unsigned       load_done_cnt = 0;
  int unsigned       store_done_cnt = 0;
  int unsigned       check_cnt = 0;
  bit                ready_random;
  string             test_name;

  copy_engine_top dut0 (.*);

  always #50 clk_i = ~clk_i;

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic bit rand_bit();
    return next_rand() > 32'h7fff_ffff;
  endfunction

  function automatic logic [MEM_DW-1:0] expected_word(input logic [MEM_AW-1:0] addr);
    return ref_mem[addr];
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %0h, actual %0h", {test_name, " ", name},
               expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s (during %s)", reason, test_name);
    $display("*** FAILED ***");
    $fatal(1, "run aborted");
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  // done is a one-cycle pulse, sampled mid-cycle
  task automatic wait_done(input bit load_side, input string what);
    int unsigned waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run({"timeout waiting for ", what});
    end while (!(load_side ? load_done : store_done));
    idle_cycles(1);
  endtask

  task automatic feed_store(input logic [MEM_AW-1:0] base, input logic [MEM_AW:0] len,
                            input bit random_valid);
    logic [MEM_AW:0] idx;
    int unsigned     waited, done_before;
    bit              sent;
    done_before    = store_done_cnt;
    store_job.base = base;
    store_job.len  = len;
    store_start    = 1'b1;
    idle_cycles(1);
    store_start = 1'b0;
    check_value("store busy after start", 1, store_busy);
    idx    = '0;
    waited = 0;
    while (idx < len) begin
      if (!in_valid && (!random_valid || rand_bit())) begin
        in_beat.data = next_rand();
        in_valid     = 1'b1; // held until accepted
      end
      @(negedge clk_i);
      sent = in_valid && in_ready;
      if (sent) begin
        ref_mem[base + idx[MEM_AW-1:0]] = in_beat.data;
        idx    = idx + 1'b1;
        waited = 0;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT)
          abort_run("timeout waiting for in_ready on the store stream");
      end
      idle_cycles(1);
      if (sent)
        in_valid = 1'b0;
    end
    wait_done(1'b0, "store_done");
    idle_cycles(2);
    check_value("store done pulses", done_before + 1, store_done_cnt);
    check_value("store busy after done", 0, store_busy);
  endtask

  task automatic run_load(input logic [MEM_AW-1:0] base, input logic [MEM_AW:0] len,
                          input bit random_ready);
    int unsigned done_before;
    done_before   = load_done_cnt;
    exp_base      = base;
    exp_len       = len;
    beat_idx      = '0;
    ready_random  = random_ready;
    load_job.base = base;
    load_job.len  = len;
    load_start    = 1'b1;
    idle_cycles(1);
    load_start = 1'b0;
    check_value("load busy after start", 1, load_busy);
    wait_done(1'b1, "load_done");
    ready_random = 1'b0;
    idle_cycles(2);
    check_value("beat count", len, beat_idx);
    check_value("load done pulses", done_before + 1, load_done_cnt);
    check_value("load busy after done", 0, load_busy);
    exp_len = '0; // any further beat is an error
  endtask

  always @(posedge clk_i) begin
    #DRIVE_DELAY;
    out_ready = ready_random ? rand_bit() : 1'b1;
  end

  // compares output beats in order and counts done pulses
  always @(negedge clk_i) begin
    if (rst_ni && out_valid && out_ready) begin
      if (beat_idx >= exp_len)
        abort_run("output beat outside of a load job");
      check_value("load beat", expected_word(exp_base + beat_idx[MEM_AW-1:0]),
                  out_beat.data);
      beat_idx = beat_idx + 1'b1;
    end
    if (rst_ni && load_done)
      load_done_cnt++;
    if (rst_ni && store_done)
      store_done_cnt++;
  end

  initial begin
    repeat (20000) @(posedge clk_i);
    abort_run("timeout waiting for the test sequence to finish");
  end

  initial begin
    rng_state    = 32'd27;
    rst_ni       = 1'b0;
    load_job     = '0;
    store_job    = '0;
    load_start   = 1'b0;
    store_start  = 1'b0;
    in_beat      = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b0;
    ready_random = 1'b0;
    exp_base     = '0;
    exp_len      = '0;
    beat_idx     = '0;
    test_name    = "reset";
    repeat (5) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_ni = 1'b1;
    check_value("load_busy", 0, load_busy);
    check_value("store_busy", 0, store_busy);
    check_value("load_done", 0, load_done);
    check_value("store_done", 0, store_done);
    check_value("out_valid", 0, out_valid);
    check_value("in_ready", 0, in_ready);

    test_name = "single copy";
    feed_store(8'd0, 9'd16, 1'b0);
    run_load(8'd0, 9'd16, 1'b0);

    test_name = "concurrent jobs"; // both channels contend on the mixer
    fork
      feed_store(8'd64, 9'd16, 1'b0);
      run_load(8'd0, 9'd16, 1'b0);
    join
    run_load(8'd64, 9'd16, 1'b0);

    test_name = "random out_ready";
    feed_store(8'd16, 9'd16, 1'b0);
    run_load(8'd0, 9'd32, 1'b1);

    test_name = "random in_valid";
    feed_store(8'd128, 9'd24, 1'b1);
    run_load(8'd128, 9'd24, 1'b0);

    test_name = "last address";
    feed_store(8'd255, 9'd1, 1'b0);
    run_load(8'd255, 9'd1, 1'b0);

    if (check_cnt > 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("no checks were executed");
      $display("*** FAILED ***");
      $fatal(1, "empty run");
    end
  end

endmodule

/* verilog.f */
hdl/mem_pkg.sv
hdl/stream_pkg.sv
hdl/stream_fifo.sv
hdl/load_store_mixer.sv
hdl/load_streamer.sv
hdl/store_streamer.sv
hdl/scratch_mem.sv
hdl/copy_engine_top.sv
testbench/tb_copy_engine.sv
